// File: spi_regs_top.f
spi_regs_pkg.sv
spi_rx.sv
reg_bank.sv
cs_router.sv
led_blinker.sv
spi_regs_top.sv
spi_regs_top_chk.sv
spi_regs_top_tb.sv

// File: spi_regs_top_tb.sv
//////////////////////////////////////////////////
// testbench for the spi register bank
// spi frame driver, lcg stimulus, register mirror
// and compare process
//////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_regs_top_tb
  import spi_regs_pkg::*;
;

  // one blink step is 2**blink_log2 cycles, watch two full gray cycles
  localparam int n_frames       = 24;
  localparam int blink_cycles   = 8 * (1 << blink_log2) + 8;
  localparam int timeout_cycles = n_frames * (17 * 8 + 20) * 2 + blink_cycles;

  logic clk, rst, sclk, cs_n, mosi, special;
  logic [1:0] led;
  logic adc_cs_n, flash_cs_n, frame_err;

  // register mirror and expected error flag
  logic [data_bits-1:0] mirror_led;
  logic [data_bits-1:0] mirror_route;
  logic                 exp_err;
  logic [31:0]          lcg_state = 32'd55;
  int err_seen, n_checks, n_errors, cycle_cnt;
  event check_ev;

  spi_regs_top spi_regs_top_i (
    .clk (clk), .rst (rst), .sclk (sclk), .cs_n (cs_n), .mosi (mosi), .special (special),
    .led (led), .adc_cs_n (adc_cs_n), .flash_cs_n (flash_cs_n), .frame_err (frame_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // register file model
  // special or a wrong count writes nothing
  function automatic void ref_frame(input logic [15:0] word, input int nbits, input logic spec);
    exp_err = !spec && (nbits != 0) && (nbits != frame_bits);
    if (!spec && nbits == frame_bits)
    begin
      if (word[15:8] == addr_led)
        mirror_led = word[7:0];
      else if (word[15:8] == addr_route)
        mirror_route = word[7:0];
    end
  endfunction

  function automatic logic ref_cs(input logic [7:0] route, input logic host, input logic [7:0] code);
    return (route == code) ? host : 1'b1;
  endfunction

  // gray order 00 01 11 10
  function automatic logic [1:0] gray_next(input logic [1:0] g);
    case (g)
      2'b00:   return 2'b01;
      2'b01:   return 2'b11;
      2'b11:   return 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  task automatic check_led(input logic [1:0] got, input logic [1:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("[FAIL] %0t led got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_cs(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("[FAIL] %0t frame_err pulse got %b expected %b", $time, got, exp);
    end
  endtask

  // frame_err pulses per frame, sampled away from the active edge
  always @(negedge clk)
    if (frame_err === 1'b1)
      err_seen++;

  // compare process, woken by the stimulus
  initial
  begin
    forever
    begin
      @(check_ev);
      if (!mirror_led[led_blink_bit])
        check_led(led, mirror_led[1:0]);
      check_cs("adc_cs_n", adc_cs_n, ref_cs(mirror_route, cs_n, route_adc));
      check_cs("flash_cs_n", flash_cs_n, ref_cs(mirror_route, cs_n, route_flash));
      check_err(err_seen != 0, exp_err);
      if (err_seen > 1)
      begin
        n_errors++;
        $display("frame_err pulsed %0d times for a single frame", err_seen);
      end
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // the extra edge keeps the next drive clear of the compare
  task automatic do_check();
    -> check_ev;
    @(negedge clk);
  endtask

  // msb first, 4 cycles low then 4 high per bit
  task automatic send_frame(input logic [31:0] word, input int nbits, input logic spec);
    @(negedge clk);
    special = spec;
    cs_n = 1'b0;
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi = word[i];
      sclk = 1'b0;
      wait_cycles(4);
      sclk = 1'b1;
      wait_cycles(4);
    end
    sclk = 1'b0;
    wait_cycles(4);
    cs_n = 1'b1;
    special = 1'b0;
  endtask

  task automatic frame_test(input logic [31:0] word, input int nbits, input logic spec);
    err_seen = 0;
    ref_frame(word[15:0], nbits, spec);
    send_frame(word, nbits, spec);
    wait_cycles(10);
    do_check();
  endtask

  // bare cs_n window with no sclk
  task automatic cs_window();
    err_seen = 0;
    exp_err = 1'b0;
    cs_n = 1'b0;
    wait_cycles(10);
    do_check();
    cs_n = 1'b1;
    wait_cycles(10);
    do_check();
  endtask

  task automatic watch_blink();
    logic [1:0] prev;
    int changes;
    prev = led;
    changes = 0;
    repeat (blink_cycles)
    begin
      @(negedge clk);
      if (led !== prev)
      begin
        check_led(led, gray_next(prev));
        changes++;
        prev = led;
      end
    end
    if (changes < 4)
    begin
      n_errors++;
      $display("blinking led changed only %0d times", changes);
    end
  endtask

  initial
  begin
    logic [7:0] data;
    logic [7:0] addr;
    rst = 1'b1;
    sclk = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    special = 1'b0;
    mirror_led = '0;
    mirror_route = '0;
    exp_err = 1'b0;
    err_seen = 0;
    n_checks = 0;
    n_errors = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    wait_cycles(4);
    do_check();
    // static led writes
    repeat (8)
    begin
      data = lcg_byte() & 8'h7f;
      frame_test({16'h0, addr_led, data}, frame_bits, 1'b0);
    end
    // routing, flash last so later windows see it
    frame_test({16'h0, addr_route, 8'h55}, frame_bits, 1'b0);
    cs_window();
    frame_test({16'h0, addr_route, route_adc}, frame_bits, 1'b0);
    cs_window();
    frame_test({16'h0, addr_route, 8'h00}, frame_bits, 1'b0);
    cs_window();
    frame_test({16'h0, addr_route, route_flash}, frame_bits, 1'b0);
    cs_window();
    // wrong bit counts
    frame_test({16'h0, addr_led, ~mirror_led & 8'h7f}, 15, 1'b0);
    frame_test({15'h0, 1'b1, addr_route, route_adc}, 17, 1'b0);
    cs_window();
    // special held high, then an unused address
    frame_test({16'h0, addr_led, ~mirror_led & 8'h7f}, frame_bits, 1'b1);
    addr = lcg_byte();
    if (addr == addr_led || addr == addr_route)
      addr = addr + 8'd3;
    frame_test({16'h0, addr, lcg_byte()}, frame_bits, 1'b0);
    cs_window();
    // gray blink mode
    frame_test({16'h0, addr_led, 8'h80 | lcg_byte()}, frame_bits, 1'b0);
    watch_blink();
    $display("checks %0d, check errors %0d, assertion errors %0d",
             n_checks, n_errors, spi_regs_top_i.chk_i.fail_cnt);
    if (n_errors == 0 && spi_regs_top_i.chk_i.fail_cnt == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run did not finish within %0d cycles", timeout_cycles);
    $display("test failed");
    $finish;
  end

endmodule

// File: spi_regs_top_chk.sv
//////////////////////////////////////////////////
// bound assertions for the spi register bank
// chip-select exclusivity and strobe widths
//////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_regs_top_chk (
  input logic clk,
  input logic rst,
  input logic adc_cs_n,
  input logic flash_cs_n,
  input logic frame_valid,
  input logic frame_err
);

  // assertion failure count
  int fail_cnt = 0;

  // at most one peripheral selected
  cs_exclusive: assert property (@(posedge clk) disable iff (rst) adc_cs_n || flash_cs_n)
  else
  begin
    fail_cnt++;
    $error("adc_cs_n and flash_cs_n low together");
  end

  // a frame is either good or bad
  valid_err_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(frame_valid && frame_err))
  else
  begin
    fail_cnt++;
    $error("frame_valid and frame_err high together");
  end

  // single-cycle strobes
  valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid)
  else
  begin
    fail_cnt++;
    $error("frame_valid longer than one cycle");
  end

  err_one_cycle: assert property (@(posedge clk) disable iff (rst) frame_err |=> !frame_err)
  else
  begin
    fail_cnt++;
    $error("frame_err longer than one cycle");
  end

endmodule

bind spi_regs_top spi_regs_top_chk chk_i (
  .clk         (clk),
  .rst         (rst),
  .adc_cs_n    (adc_cs_n),
  .flash_cs_n  (flash_cs_n),
  .frame_valid (frame_valid),
  .frame_err   (frame_err)
);

// File: spi_regs_top.sv
//////////////////////////////////////////////////
// top level of the spi register bank
// receiver, registers, cs router, led blinker
//////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_regs_top
  import spi_regs_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic       special,
  output logic [1:0] led,
  output logic       adc_cs_n,
  output logic       flash_cs_n,
  output logic       frame_err
);

  logic                 frame_valid;
  logic [data_bits-1:0] frame_addr;
  logic [data_bits-1:0] frame_data;
  logic                 cs_n_sync;
  logic [data_bits-1:0] led_reg;
  logic [data_bits-1:0] route_reg;

  // spi pins into checked frames
  spi_rx spi_rx_i (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special     (special),
    .frame_valid (frame_valid),
    .frame_err   (frame_err),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .cs_n_sync   (cs_n_sync)
  );

  reg_bank reg_bank_i (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .led_reg     (led_reg),
    .route_reg   (route_reg)
  );

  // host cs_n steered to one peripheral
  cs_router cs_router_i (
    .clk        (clk),
    .rst        (rst),
    .cs_n_sync  (cs_n_sync),
    .route_reg  (route_reg),
    .adc_cs_n   (adc_cs_n),
    .flash_cs_n (flash_cs_n)
  );

  led_blinker led_blinker_i (
    .clk     (clk),
    .rst     (rst),
    .led_reg (led_reg),
    .led     (led)
  );

endmodule

// File: led_blinker.sv
//////////////////////////////////////////////////
// led driver with static and gray blink modes
//////////////////////////////////////////////////

`timescale 1ns/100ps

module led_blinker
  import spi_regs_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [data_bits-1:0] led_reg,
  output logic [1:0]           led
);

  logic [blink_log2+1:0] blink_cnt;
  logic [1:0]            step;
  logic [1:0]            gray;

  // free-running blink timebase
  always_ff @(posedge clk)
  begin
    if (rst)
      blink_cnt <= '0;
    else
      blink_cnt <= blink_cnt + 1'b1;
  end

  // top two counter bits as step
  assign step = blink_cnt[blink_log2+1:blink_log2];

  // binary to gray
  // gives 00 01 11 10
  assign gray = step ^ (step >> 1);

  // output select, one cycle behind led_reg
  always_ff @(posedge clk)
  begin
    if (rst)
      led <= 2'b00;
    else if (led_reg[led_blink_bit])
      led <= gray;
    else
      led <= led_reg[1:0];
  end

endmodule

// File: cs_router.sv
//////////////////////////////////////////////////
// chip-select router for adc and flash
//////////////////////////////////////////////////

`timescale 1ns/100ps

module cs_router
  import spi_regs_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cs_n_sync,
  input  logic [data_bits-1:0] route_reg,
  output logic                 adc_cs_n,
  output logic                 flash_cs_n
);

  logic sel_adc;
  logic sel_flash;

  // route decode
  // unknown codes select nothing
  assign sel_adc   = (route_reg == route_adc);
  assign sel_flash = (route_reg == route_flash);

  // registered outputs
  // deselected side held high
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      adc_cs_n   <= 1'b1;
      flash_cs_n <= 1'b1;
    end
    else
    begin
      adc_cs_n   <= sel_adc   ? cs_n_sync : 1'b1;
      flash_cs_n <= sel_flash ? cs_n_sync : 1'b1;
    end
  end

endmodule

// File: reg_bank.sv
//////////////////////////////////////////////////
// register bank with led and route registers
// written from checked spi frames
//////////////////////////////////////////////////

`timescale 1ns/100ps

module reg_bank
  import spi_regs_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frame_valid,
  input  logic [data_bits-1:0] frame_addr,
  input  logic [data_bits-1:0] frame_data,
  output logic [data_bits-1:0] led_reg,
  output logic [data_bits-1:0] route_reg
);

  logic wr_led;
  logic wr_route;

  // address decode
  // qualified by the frame strobe
  assign wr_led   = frame_valid && (frame_addr == addr_led);
  assign wr_route = frame_valid && (frame_addr == addr_route);

  // led register
  // bits 1:0 static pattern
  // bit 7 blink enable
  always_ff @(posedge clk)
  begin
    if (rst)
      led_reg <= '0;
    else if (wr_led)
      led_reg <= frame_data;
  end

  // route register
  // zero after reset so both chip selects stay high
  always_ff @(posedge clk)
  begin
    if (rst)
      route_reg <= '0;
    else if (wr_route)
      route_reg <= frame_data;
  end

endmodule

// File: spi_rx.sv
//////////////////////////////////////////////////
// spi frame receiver in the clk domain
// pin synchronizers, sclk and cs_n edge detect,
// shift register and bit-count check
//////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_rx
  import spi_regs_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sclk,
  input  logic                 cs_n,
  input  logic                 mosi,
  input  logic                 special,
  output logic                 frame_valid,
  output logic                 frame_err,
  output logic [data_bits-1:0] frame_addr,
  output logic [data_bits-1:0] frame_data,
  output logic                 cs_n_sync
);

  // extra headroom so long frames saturate instead of wrapping
  localparam int cnt_w = $clog2(frame_bits) + 2;

  // pin vector order is special, mosi, cs_n, sclk
  // cs_n idles high
  localparam logic [3:0] pin_idle = 4'b0010;

  logic [3:0]            pin_sync [sync_stages];
  logic                  sclk_s;
  logic                  mosi_s;
  logic                  special_s;
  logic                  sclk_prev;
  logic                  cs_prev;
  logic                  sclk_rise;
  logic                  cs_rise;
  logic [frame_bits-1:0] shift_q;
  logic [cnt_w-1:0]      bit_cnt;

  // pin synchronizer chain
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < sync_stages; i++)
        pin_sync[i] <= pin_idle;
    end
    else
    begin
      pin_sync[0] <= {special, mosi, cs_n, sclk};
      for (int i = 1; i < sync_stages; i++)
        pin_sync[i] <= pin_sync[i-1];
    end
  end

  assign sclk_s    = pin_sync[sync_stages-1][0];
  assign cs_n_sync = pin_sync[sync_stages-1][1];
  assign mosi_s    = pin_sync[sync_stages-1][2];
  assign special_s = pin_sync[sync_stages-1][3];

  // previous levels for edge detect
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_prev <= 1'b0;
      cs_prev   <= 1'b1;
    end
    else
    begin
      sclk_prev <= sclk_s;
      cs_prev   <= cs_n_sync;
    end
  end

  assign sclk_rise = sclk_s & ~sclk_prev;
  assign cs_rise   = cs_n_sync & ~cs_prev;

  // msb first, shift only while selected and special low
  always_ff @(posedge clk)
  begin
    if (sclk_rise && !cs_n_sync && !special_s)
      shift_q <= {shift_q[frame_bits-2:0], mosi_s};
  end

  // bit counter, cleared at frame end
  always_ff @(posedge clk)
  begin
    if (rst)
      bit_cnt <= '0;
    else if (cs_rise)
      bit_cnt <= '0;
    else if (sclk_rise && !cs_n_sync && !special_s && !(&bit_cnt))
      bit_cnt <= bit_cnt + 1'b1;
  end

  // frame end check
  // zero bits means a bare cs_n window, no report
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      frame_valid <= 1'b0;
      frame_err   <= 1'b0;
    end
    else
    begin
      frame_valid <= cs_rise && (bit_cnt == cnt_w'(frame_bits));
      frame_err   <= cs_rise && (bit_cnt != '0) && (bit_cnt != cnt_w'(frame_bits));
    end
  end

  // high byte is the address
  always_ff @(posedge clk)
  begin
    if (cs_rise)
    begin
      frame_addr <= shift_q[frame_bits-1 -: data_bits];
      frame_data <= shift_q[data_bits-1:0];
    end
  end

endmodule

// File: spi_regs_pkg.sv
//////////////////////////////////////////////////
// shared constants for the spi register bank
// frame widths, register addresses, route codes
// and led blinker constants
//////////////////////////////////////////////////

package spi_regs_pkg;

  // full frame is address byte then data byte
  localparam int frame_bits = 16;

  // data byte and register width
  localparam int data_bits = 8;

  // register map
  // all other addresses are ignored
  localparam logic [data_bits-1:0] addr_led   = 8'd1;
  localparam logic [data_bits-1:0] addr_route = 8'd2;

  // route register codes
  // anything else keeps both peripherals deselected
  localparam logic [data_bits-1:0] route_adc   = 8'd1;
  localparam logic [data_bits-1:0] route_flash = 8'd2;

  // led register bit 7 switches to gray blink mode
  localparam int led_blink_bit = 7;

  // low counter bits skipped per blink step
  localparam int blink_log2 = 6;

  // flop depth for the async spi pins
  localparam int sync_stages = 2;

endpackage
